//--- vlog.f
+incdir+testbench
source/bus_pkg.sv
source/loader_pkg.sv
source/cpu_timing.sv
source/loader_regs.sv
source/bus_decoder.sv
source/byte_lane_ram.sv
source/m68k_mem_system.sv
testbench/tb_top.sv

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ============================================================
// Reference model, stepped once per clock
// ============================================================
localparam int POR_MAX = 2**bus_pkg::POR_BITS - 1;          // Last power-on count

logic [bus_pkg::DATA_W-1:0]    rom_m  [2**bus_pkg::ROM_AW];
logic [bus_pkg::DATA_W-1:0]    vram_m [2**bus_pkg::VRAM_AW];
logic [bus_pkg::DATA_W-1:0]    ram_m  [2**bus_pkg::RAM_AW];
logic [loader_pkg::LDR_DW-1:0] slot_m [2];                  // Loader byte pair
logic [loader_pkg::CTRL_W-1:0] ctrl_m;
logic                          ldr_wr_m;                    // Strobe of last cycle
logic                          word_wr_m;                   // ROM word write pending
int                            por_m;
int                            baud_m;
logic                          phi1_m;
logic                          phi2_m;
logic                          baud_clk_m;
logic [bus_pkg::DATA_W-1:0]    din_m;                       // Expected CPU read data
logic [loader_pkg::LDR_DW-1:0] ldr_rdata_m;
logic                          din_chk_m;
logic                          ldr_chk_m;

// Region from address bits 17..15
function automatic bus_pkg::region_e region_of(input cpu_addr_t a);
  case (a[bus_pkg::REGION_MSB:bus_pkg::REGION_LSB])
    3'd0, 3'd1: return bus_pkg::REG_ROM;
    3'd2:       return bus_pkg::REG_VRAM;
    default:    return bus_pkg::REG_RAM;                    // Mirrored over 3..7
  endcase
endfunction

function automatic logic is_periph(input cpu_addr_t a);
  return a[bus_pkg::ADDR_HI:bus_pkg::PERIPH_LSB] == bus_pkg::PERIPH_TAG;
endfunction

// Byte lanes merged into a stored word
function automatic logic [15:0] merge_lanes(input logic [15:0] old, wd, input logic ub, lb);
  merge_lanes = old;
  if (ub)
    merge_lanes[15:8] = wd[15:8];
  if (lb)
    merge_lanes[7:0] = wd[7:0];
endfunction

// ============================================================
// Compare tasks
// ============================================================
task automatic check_word(input logic [bus_pkg::DATA_W-1:0] got, exp, input string what);
  if (got !== exp)
    fail_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_byte(input logic [loader_pkg::LDR_DW-1:0] got, exp, input string what);
  if (got !== exp)
    fail_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_bit(input logic got, exp, input string what);
  if (got !== exp)
    fail_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

// Outputs against the state after the last edge
task automatic check_outputs();
  check_bit(o_cpu_reset, por_m < POR_MAX || ctrl_m[loader_pkg::CTRL_RESET_BIT],
            "o_cpu_reset");
  check_bit(o_cpu_halt_n, !ctrl_m[loader_pkg::CTRL_HALT_BIT], "o_cpu_halt_n");
  check_bit(o_phi1, phi1_m, "o_phi1");
  check_bit(o_phi2, phi2_m, "o_phi2");
  check_bit(o_baud_clk, baud_clk_m, "o_baud_clk");
  check_bit(o_vpa_n, !(is_periph(i_cpu_addr) && !i_cpu_as_n), "o_vpa_n");  // Combinational
  if (din_chk_m)
    check_word(o_cpu_din, din_m, "o_cpu_din");
  if (ldr_chk_m)
    check_byte(o_ldr_rdata, ldr_rdata_m, "o_ldr_rdata");
endtask

// One clock edge with the inputs now applied
task automatic advance_model();
  logic [bus_pkg::DATA_W-1:0] rom_q;
  logic [7:0]                 tgt;
  bus_pkg::region_e           rgn;
  rgn   = region_of(i_cpu_addr);
  tgt   = i_ldr_addr[loader_pkg::TARGET_MSB:loader_pkg::TARGET_LSB];
  rom_q = ctrl_m[loader_pkg::CTRL_OWNER_BIT] ? rom_m[i_ldr_addr[bus_pkg::ROM_AW:1]]
                                              : rom_m[i_cpu_addr[bus_pkg::ROM_AW:1]];
  // Reads see memory before this edge's writes
  if (is_periph(i_cpu_addr))
    din_m = '0;
  else if (rgn == bus_pkg::REG_ROM)
    din_m = rom_q;
  else if (rgn == bus_pkg::REG_VRAM)
    din_m = vram_m[i_cpu_addr[bus_pkg::VRAM_AW:1]];
  else
    din_m = ram_m[i_cpu_addr[bus_pkg::RAM_AW:1]];
  ldr_rdata_m = i_ldr_addr[0] ? rom_q[7:0] : rom_q[15:8];   // Even byte is upper
  din_chk_m   = chk_din;
  ldr_chk_m   = chk_ldr;
  if (word_wr_m)
    rom_m[i_ldr_addr[bus_pkg::ROM_AW:1]] = {slot_m[0], slot_m[1]};
  if (!i_cpu_as_n && !i_cpu_rw && rgn == bus_pkg::REG_VRAM)
    vram_m[i_cpu_addr[bus_pkg::VRAM_AW:1]] = merge_lanes(vram_m[i_cpu_addr[bus_pkg::VRAM_AW:1]],
                                             i_cpu_dout, !i_cpu_uds_n, !i_cpu_lds_n);
  if (!i_cpu_as_n && !i_cpu_rw && rgn == bus_pkg::REG_RAM)
    ram_m[i_cpu_addr[bus_pkg::RAM_AW:1]] = merge_lanes(ram_m[i_cpu_addr[bus_pkg::RAM_AW:1]],
                                           i_cpu_dout, !i_cpu_uds_n, !i_cpu_lds_n);
  if (i_ldr_wr && tgt == loader_pkg::TARGET_MEM)
    slot_m[i_ldr_addr[0]] = i_ldr_wdata;
  if (i_reset)
  begin
    ctrl_m     = loader_pkg::CTRL_INIT;
    ldr_wr_m   = 1'b0;
    word_wr_m  = 1'b0;
    por_m      = 0;
    phi1_m     = 1'b0;
    phi2_m     = 1'b0;
    baud_m     = 0;
    baud_clk_m = 1'b0;
  end
  else
  begin
    word_wr_m = i_ldr_wr && !ldr_wr_m && tgt == loader_pkg::TARGET_MEM && i_ldr_addr[0];
    ldr_wr_m  = i_ldr_wr;
    if (i_ldr_wr && tgt == loader_pkg::TARGET_CTRL)
      ctrl_m = i_ldr_wdata;
    if (por_m < POR_MAX)
      por_m++;
    phi2_m     = phi1_m;
    phi1_m     = !phi1_m;
    baud_clk_m = baud_m >= bus_pkg::BAUD_HIGH_FROM;         // From the old count
    baud_m     = (baud_m == bus_pkg::BAUD_LAST) ? 0 : baud_m + 1;
  end
endtask

`endif

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  typedef logic [bus_pkg::ADDR_HI:bus_pkg::ADDR_LO] cpu_addr_t;

  localparam logic [31:0] SEED        = 32'h5ab2_847a;
  localparam int          N_OTHER     = 4;                  // Writes to unused targets
  localparam int          N_PAIRS     = 48;                 // Loader words into ROM
  localparam int          N_POOL      = 16;                 // Words per RAM under test
  localparam int          N_CPU_OPS   = 400;
  localparam int          N_PERIPH    = 200;
  localparam int          N_OPS       = 4 + N_OTHER + 5 * N_PAIRS + 2 * N_POOL + N_CPU_OPS
                                        + N_PERIPH;
  localparam int          CYCLE_LIMIT = N_OPS * 4 + 2000;
  localparam logic [31:0] CTRL_ADDR   = {loader_pkg::TARGET_CTRL, 24'h0};

  logic                          clk_cpu;
  logic                          i_reset;
  cpu_addr_t                     i_cpu_addr;
  logic                          i_cpu_as_n;
  logic                          i_cpu_rw;
  logic                          i_cpu_uds_n;
  logic                          i_cpu_lds_n;
  logic [bus_pkg::DATA_W-1:0]    i_cpu_dout;
  logic [bus_pkg::DATA_W-1:0]    o_cpu_din;
  logic                          o_vpa_n;
  logic                          o_phi1;
  logic                          o_phi2;
  logic                          o_cpu_reset;
  logic                          o_cpu_halt_n;
  logic                          o_baud_clk;
  logic                          i_ldr_wr;
  logic [loader_pkg::LDR_AW-1:0] i_ldr_addr;
  logic [loader_pkg::LDR_DW-1:0] i_ldr_wdata;
  logic [loader_pkg::LDR_DW-1:0] o_ldr_rdata;
  logic                          chk_din;                   // Check read data next cycle
  logic                          chk_ldr;
  logic                          model_on = 1'b0;
  int                            cycles;
  logic [15:0]                   rom_pool  [$];             // Loaded ROM byte addresses
  logic [13:0]                   vram_pool [$];
  logic [13:0]                   ram_pool  [$];

  `include "tb_model.svh"

  m68k_mem_system uut (.*);

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_cpu);
    #1;
    chk_din = 1'b0;
    chk_ldr = 1'b0;
  endtask

  // Strobe held one cycle and the address one more for the word write
  task automatic ldr_write(input logic [31:0] addr, input logic [7:0] data);
    next_cycle();
    i_ldr_wr    = 1'b1;
    i_ldr_addr  = addr;
    i_ldr_wdata = data;
    next_cycle();
    i_ldr_wr    = 1'b0;
  endtask

  task automatic ldr_read(input logic [31:0] addr);
    next_cycle();
    i_ldr_addr = addr;
    chk_ldr    = 1'b1;
  endtask

  task automatic cpu_cycle(input logic [23:0] addr, input logic as_n, rw, uds_n, lds_n,
                           input logic [15:0] dout, input logic chk);
    next_cycle();
    i_cpu_addr  = addr[23:1];
    i_cpu_as_n  = as_n;
    i_cpu_rw    = rw;
    i_cpu_uds_n = uds_n;
    i_cpu_lds_n = lds_n;
    i_cpu_dout  = dout;
    chk_din     = chk;
  endtask

  function automatic logic [23:0] mem_addr(input logic [2:0] rgn, input logic [13:0] word);
    return {6'b0, rgn, word, 1'b0};
  endfunction

  initial
  begin
    clk_cpu = 1'b0;
    forever #2 clk_cpu = ~clk_cpu;                          // 4 ns period
  end

  // Compare after the inputs have settled
  initial
  begin
    @(posedge clk_cpu);
    forever
    begin
      @(negedge clk_cpu);
      if (model_on)
        check_outputs();
      advance_model();
      model_on = 1'b1;
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk_cpu);
      cycles++;
    end
    fail_run($sformatf("Timeout, tests still running after %0d cycles", cycles));
  end

  initial
  begin
    logic [31:0] wa;
    logic [23:0] a;
    logic        rw;
    void'($urandom(SEED));
    i_reset     = 1'b1;
    i_cpu_addr  = '0;
    i_cpu_as_n  = 1'b1;
    i_cpu_rw    = 1'b1;
    i_cpu_uds_n = 1'b1;
    i_cpu_lds_n = 1'b1;
    i_cpu_dout  = '0;
    i_ldr_wr    = 1'b0;
    i_ldr_addr  = '0;
    i_ldr_wdata = '0;
    chk_din     = 1'b0;
    chk_ldr     = 1'b0;
    repeat (2) next_cycle();
    i_reset = 1'b0;
    while (o_cpu_reset !== 1'b0)
      next_cycle();                                         // Power-on hold runs out

    // ============================================================
    // Control register
    // ============================================================
    ldr_write(CTRL_ADDR, 8'h00);                            // Release halt
    ldr_write(CTRL_ADDR, 8'h01);                            // Force CPU reset
    repeat (N_OTHER) ldr_write({8'($urandom_range(1, 254)), 24'h0}, 8'($urandom));
    ldr_write(CTRL_ADDR, 8'h02);                            // Loader owns ROM

    // ============================================================
    // ROM load through the loader, then CPU readback
    // ============================================================
    for (int i = 0; i < N_PAIRS; i++)
    begin
      wa = {loader_pkg::TARGET_MEM, 8'h00, 15'($urandom), 1'b0};
      ldr_write(wa, 8'($urandom));                          // Upper byte
      ldr_write(wa | 32'd1, 8'($urandom));                  // Odd byte starts the write
      ldr_read(wa);
      ldr_read(wa | 32'd1);
      rom_pool.push_back(wa[15:0]);
    end
    ldr_write(CTRL_ADDR, 8'h00);
    foreach (rom_pool[i])
      cpu_cycle({8'h00, rom_pool[i]}, 1'b0, 1'b1, 1'b0, 1'b0, '0, 1'b1);

    // ============================================================
    // VRAM and RAM with random byte lanes
    // ============================================================
    for (int i = 0; i < N_POOL; i++)
    begin
      vram_pool.push_back(14'($urandom));
      ram_pool.push_back(14'($urandom));
      cpu_cycle(mem_addr(3'd2, vram_pool[i]), 1'b0, 1'b0, 1'b0, 1'b0, 16'($urandom), 1'b0);
      cpu_cycle(mem_addr(3'($urandom_range(3, 7)), ram_pool[i]), 1'b0, 1'b0, 1'b0, 1'b0,
                16'($urandom), 1'b0);
    end
    for (int i = 0; i < N_CPU_OPS; i++)
    begin
      case ($urandom_range(0, 2))
        0:       a = mem_addr(3'd2, vram_pool[$urandom_range(0, N_POOL - 1)]);
        1:       a = mem_addr(3'($urandom_range(3, 7)), ram_pool[$urandom_range(0, N_POOL - 1)]);
        default: a = {8'h00, rom_pool[$urandom_range(0, N_PAIRS - 1)]};  // Writes ignored
      endcase
      rw = 1'($urandom);
      cpu_cycle(a, 1'b0, rw, 1'($urandom), 1'($urandom), 16'($urandom), rw);
    end

    // ============================================================
    // Peripheral window
    // ============================================================
    for (int i = 0; i < N_PERIPH; i++)
    begin
      if ($urandom_range(0, 1))
        a = {bus_pkg::PERIPH_TAG, 18'($urandom)};
      else
        a = 24'($urandom);
      cpu_cycle(a, 1'($urandom), 1'b1, 1'b1, 1'b1, '0, is_periph(a[23:1]));
    end

    repeat (3) next_cycle();                                // Last reads reach the checker
    $display("Regression passed");
    $finish;
  end

endmodule

//--- source/m68k_mem_system.sv
`timescale 1ns/1ps

module m68k_mem_system
(
  input  logic                                      clk_cpu,
  input  logic                                      i_reset,
  // 68000 bus
  input  logic [bus_pkg::ADDR_HI:bus_pkg::ADDR_LO]  i_cpu_addr,
  input  logic                                      i_cpu_as_n,
  input  logic                                      i_cpu_rw,
  input  logic                                      i_cpu_uds_n,
  input  logic                                      i_cpu_lds_n,
  input  logic [bus_pkg::DATA_W-1:0]                i_cpu_dout,
  output logic [bus_pkg::DATA_W-1:0]                o_cpu_din,
  output logic                                      o_vpa_n,
  // CPU timing and control
  output logic                                      o_phi1,
  output logic                                      o_phi2,
  output logic                                      o_cpu_reset,
  output logic                                      o_cpu_halt_n,
  output logic                                      o_baud_clk,  // 16x for the UART
  // Serial loader
  input  logic                                      i_ldr_wr,
  input  logic [loader_pkg::LDR_AW-1:0]             i_ldr_addr,
  input  logic [loader_pkg::LDR_DW-1:0]             i_ldr_wdata,
  output logic [loader_pkg::LDR_DW-1:0]             o_ldr_rdata
);

  logic                              ctrl_reset;
  logic                              mem_owner;
  logic                              word_wr;
  logic [bus_pkg::DATA_W-1:0]        word_data;
  logic                              vram_we;
  logic                              ram_we;
  logic [bus_pkg::DATA_W-1:0]        rom_q;
  logic [bus_pkg::DATA_W-1:0]        vram_q;
  logic [bus_pkg::DATA_W-1:0]        ram_q;
  logic [bus_pkg::ROM_AW-1:0]        rom_addr;
  logic                              ldr_odd_q;   // Byte select of last read

  // ============================================================
  // Timing, loader and decode
  // ============================================================
  cpu_timing timing (
    .i_clk(clk_cpu), .i_reset(i_reset), .i_ctrl_reset(ctrl_reset),
    .o_cpu_reset(o_cpu_reset), .o_phi1(o_phi1), .o_phi2(o_phi2),
    .o_baud_clk(o_baud_clk)
  );

  loader_regs loader (
    .clk_cpu(clk_cpu), .i_reset(i_reset), .i_ldr_wr(i_ldr_wr),
    .i_ldr_addr(i_ldr_addr), .i_ldr_wdata(i_ldr_wdata),
    .o_ctrl_reset(ctrl_reset), .o_mem_owner(mem_owner), .o_cpu_halt_n(o_cpu_halt_n),
    .o_word_wr(word_wr), .o_word_data(word_data)
  );

  bus_decoder decoder (
    .clk_cpu(clk_cpu), .i_cpu_addr(i_cpu_addr), .i_cpu_as_n(i_cpu_as_n),
    .i_cpu_rw(i_cpu_rw), .i_rom_q(rom_q), .i_vram_q(vram_q), .i_ram_q(ram_q),
    .o_vpa_n(o_vpa_n), .o_vram_we(vram_we), .o_ram_we(ram_we), .o_cpu_din(o_cpu_din)
  );

  // ============================================================
  // Memories
  // ============================================================
  // Loader takes the ROM read port while it owns memory
  assign rom_addr = mem_owner ? i_ldr_addr[bus_pkg::ROM_AW:1]
                              : i_cpu_addr[bus_pkg::ROM_AW:1];

  byte_lane_ram #(.AW(bus_pkg::ROM_AW)) rom_mem (
    .clk_cpu(clk_cpu), .i_addr(rom_addr), .i_we(1'b0),     // Read only to the CPU
    .i_ub(!i_cpu_uds_n), .i_lb(!i_cpu_lds_n), .i_wdata(i_cpu_dout), .o_rdata(rom_q),
    .i_b_we(word_wr), .i_b_addr(i_ldr_addr[bus_pkg::ROM_AW:1]), .i_b_wdata(word_data)
  );

  byte_lane_ram #(.AW(bus_pkg::VRAM_AW)) vram_mem (
    .clk_cpu(clk_cpu), .i_addr(i_cpu_addr[bus_pkg::VRAM_AW:1]), .i_we(vram_we),
    .i_ub(!i_cpu_uds_n), .i_lb(!i_cpu_lds_n), .i_wdata(i_cpu_dout), .o_rdata(vram_q),
    .i_b_we(1'b0), .i_b_addr('0), .i_b_wdata('0)            // Video port not used
  );

  byte_lane_ram #(.AW(bus_pkg::RAM_AW)) ram_mem (
    .clk_cpu(clk_cpu), .i_addr(i_cpu_addr[bus_pkg::RAM_AW:1]), .i_we(ram_we),
    .i_ub(!i_cpu_uds_n), .i_lb(!i_cpu_lds_n), .i_wdata(i_cpu_dout), .o_rdata(ram_q),
    .i_b_we(1'b0), .i_b_addr('0), .i_b_wdata('0)
  );

  // ============================================================
  // Loader readback
  // ============================================================
  always_ff @(posedge clk_cpu)
  begin
    ldr_odd_q <= i_ldr_addr[0];              // Matches the ROM read latency
  end

  // Even address gives the upper byte
  assign o_ldr_rdata = ldr_odd_q ? rom_q[bus_pkg::BYTE_W-1:0]
                                 : rom_q[bus_pkg::DATA_W-1:bus_pkg::BYTE_W];

endmodule

//--- source/byte_lane_ram.sv
`timescale 1ns/1ps

module byte_lane_ram
#(
  parameter int AW = 14                      // Word address bits
)
(
  input  logic                          clk_cpu,
  // Port A, CPU side with byte lanes
  input  logic [AW-1:0]                 i_addr,
  input  logic                          i_we,
  input  logic                          i_ub,          // Upper lane, D15..D8
  input  logic                          i_lb,          // Lower lane, D7..D0
  input  logic [bus_pkg::DATA_W-1:0]    i_wdata,
  output logic [bus_pkg::DATA_W-1:0]    o_rdata,
  // Port B, whole words only
  input  logic                          i_b_we,
  input  logic [AW-1:0]                 i_b_addr,
  input  logic [bus_pkg::DATA_W-1:0]    i_b_wdata
);

  logic [bus_pkg::DATA_W-1:0] mem [2**AW];

  // ============================================================
  // Writes, port B last so it wins a collision
  // ============================================================
  always_ff @(posedge clk_cpu)
  begin
    if (i_we)
    begin
      if (i_ub)
        mem[i_addr][bus_pkg::DATA_W-1:bus_pkg::BYTE_W] <= i_wdata[bus_pkg::DATA_W-1:bus_pkg::BYTE_W];
      if (i_lb)
        mem[i_addr][bus_pkg::BYTE_W-1:0] <= i_wdata[bus_pkg::BYTE_W-1:0];
    end
    if (i_b_we)
    begin
      mem[i_b_addr] <= i_b_wdata;            // Full word from the loader
    end
  end

  // Registered read, old data on a same-cycle write
  always_ff @(posedge clk_cpu)
  begin
    o_rdata <= mem[i_addr];
  end

endmodule

//--- source/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
(
  input  logic                                      clk_cpu,
  input  logic [bus_pkg::ADDR_HI:bus_pkg::ADDR_LO]  i_cpu_addr,
  input  logic                                      i_cpu_as_n,
  input  logic                                      i_cpu_rw,
  input  logic [bus_pkg::DATA_W-1:0]                i_rom_q,
  input  logic [bus_pkg::DATA_W-1:0]                i_vram_q,
  input  logic [bus_pkg::DATA_W-1:0]                i_ram_q,
  output logic                                      o_vpa_n,
  output logic                                      o_vram_we,
  output logic                                      o_ram_we,
  output logic [bus_pkg::DATA_W-1:0]                o_cpu_din
);

  bus_pkg::region_e region;
  bus_pkg::region_e region_q;                // Region of the read in flight
  logic             periph;
  logic             periph_q;
  logic             cpu_wr;

  // ============================================================
  // Address decode
  // ============================================================
  always_comb
  begin
    case (i_cpu_addr[bus_pkg::REGION_MSB:bus_pkg::REGION_LSB])
      3'd0, 3'd1: region = bus_pkg::REG_ROM;
      3'd2:       region = bus_pkg::REG_VRAM;
      default:    region = bus_pkg::REG_RAM;  // RAM mirrored in 3..7
    endcase
  end

  // 0x600000 window
  assign periph  = (i_cpu_addr[bus_pkg::ADDR_HI:bus_pkg::PERIPH_LSB] == bus_pkg::PERIPH_TAG);
  assign o_vpa_n = !(periph && !i_cpu_as_n);  // Peripheral cycle to the CPU

  // Write strobes, ROM is never written by the CPU
  assign cpu_wr    = !i_cpu_as_n && !i_cpu_rw;
  assign o_vram_we = cpu_wr && region == bus_pkg::REG_VRAM;
  assign o_ram_we  = cpu_wr && region == bus_pkg::REG_RAM;

  // ============================================================
  // Read data, aligned with the RAM outputs
  // ============================================================
  always_ff @(posedge clk_cpu)
  begin
    region_q <= region;
    periph_q <= periph;
  end

  always_comb
  begin
    if (periph_q)
      o_cpu_din = '0;                        // No peripherals here
    else
    begin
      case (region_q)
        bus_pkg::REG_ROM:  o_cpu_din = i_rom_q;
        bus_pkg::REG_VRAM: o_cpu_din = i_vram_q;
        default:           o_cpu_din = i_ram_q;
      endcase
    end
  end

endmodule

//--- source/loader_regs.sv
`timescale 1ns/1ps

module loader_regs
(
  input  logic                             clk_cpu,
  input  logic                             i_reset,
  input  logic                             i_ldr_wr,       // Level strobe
  input  logic [loader_pkg::LDR_AW-1:0]    i_ldr_addr,
  input  logic [loader_pkg::LDR_DW-1:0]    i_ldr_wdata,
  output logic                             o_ctrl_reset,
  output logic                             o_mem_owner,
  output logic                             o_cpu_halt_n,
  output logic                             o_word_wr,      // One-cycle pulse
  output logic [bus_pkg::DATA_W-1:0]       o_word_data
);

  loader_pkg::ldr_target_e              target;
  logic [loader_pkg::CTRL_W-1:0]        ctrl;
  logic [loader_pkg::LDR_DW-1:0]        byte_slot [2];
  logic                                 ldr_wr_q;        // Strobe of last cycle
  logic                                 wr_rise;

  // ============================================================
  // Target decode
  // ============================================================
  always_comb
  begin
    case (i_ldr_addr[loader_pkg::TARGET_MSB:loader_pkg::TARGET_LSB])
      loader_pkg::TARGET_MEM:  target = loader_pkg::TGT_MEM;
      loader_pkg::TARGET_CTRL: target = loader_pkg::TGT_CTRL;
      default:                 target = loader_pkg::TGT_OTHER;
    endcase
  end

  assign wr_rise = i_ldr_wr && !ldr_wr_q;

  // ============================================================
  // Control register and word-write pulse
  // ============================================================
  always_ff @(posedge clk_cpu)
  begin
    if (i_reset)
    begin
      ctrl      <= loader_pkg::CTRL_INIT;    // Starts halted
      ldr_wr_q  <= 1'b0;
      o_word_wr <= 1'b0;
    end
    else
    begin
      ldr_wr_q <= i_ldr_wr;
      if (i_ldr_wr && target == loader_pkg::TGT_CTRL)
        ctrl <= i_ldr_wdata;                 // Every strobed cycle reloads
      // Odd byte completes the word, once per strobe edge
      o_word_wr <= wr_rise && target == loader_pkg::TGT_MEM && i_ldr_addr[0];
    end
  end

  // Byte pairing, slot 0 is the upper byte
  always_ff @(posedge clk_cpu)
  begin
    if (i_ldr_wr && target == loader_pkg::TGT_MEM)
    begin
      byte_slot[i_ldr_addr[0]] <= i_ldr_wdata;
    end
  end

  assign o_word_data  = {byte_slot[0], byte_slot[1]};

  // Control bits out
  assign o_ctrl_reset = ctrl[loader_pkg::CTRL_RESET_BIT];
  assign o_mem_owner  = ctrl[loader_pkg::CTRL_OWNER_BIT];
  assign o_cpu_halt_n = !ctrl[loader_pkg::CTRL_HALT_BIT];    // Active low

endmodule

//--- source/cpu_timing.sv
`timescale 1ns/1ps

module cpu_timing
(
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_ctrl_reset,                 // Reset bit from loader
  output logic o_cpu_reset,
  output logic o_phi1,
  output logic o_phi2,
  output logic o_baud_clk
);

  logic [bus_pkg::POR_BITS-1:0] por_cnt;
  logic                         por_done;
  logic [bus_pkg::BAUD_W-1:0]   baud_cnt;

  // ============================================================
  // Power-on reset
  // ============================================================
  assign por_done = &por_cnt;                // All ones ends the hold

  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      por_cnt <= '0;
    end
    else if (!por_done)
    begin
      por_cnt <= por_cnt + 1'b1;             // Stops at all ones
    end
  end

  // Power-on hold or loader request
  assign o_cpu_reset = !por_done || i_ctrl_reset;

  // ============================================================
  // Phi enables
  // ============================================================
  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      o_phi1 <= 1'b0;
      o_phi2 <= 1'b0;
    end
    else
    begin
      o_phi1 <= !o_phi1;                     // Half the CPU clock
      o_phi2 <= o_phi1;                      // Opposite phase
    end
  end

  // ============================================================
  // Baud clock, 16x for the serial port
  // ============================================================
  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      baud_cnt   <= '0;
      o_baud_clk <= 1'b0;
    end
    else
    begin
      if (baud_cnt == bus_pkg::BAUD_W'(bus_pkg::BAUD_LAST))
        baud_cnt <= '0;                      // Wrap after 163 states
      else
        baud_cnt <= baud_cnt + 1'b1;
      // Upper part of the count, one cycle late
      o_baud_clk <= (baud_cnt >= bus_pkg::BAUD_W'(bus_pkg::BAUD_HIGH_FROM));
    end
  end

endmodule

//--- source/loader_pkg.sv
package loader_pkg;

  // ============================================================
  // Serial loader address space
  // ============================================================
  localparam int LDR_AW = 32;                // Loader byte address
  localparam int LDR_DW = 8;                 // One byte per transfer

  // Top byte of the loader address picks the target
  localparam int         TARGET_MSB  = 31;
  localparam int         TARGET_LSB  = 24;
  localparam logic [7:0] TARGET_MEM  = 8'h00;
  localparam logic [7:0] TARGET_CTRL = 8'hFF;

  // ============================================================
  // CPU control register
  // ============================================================
  localparam int CTRL_W         = 8;
  localparam int CTRL_RESET_BIT = 0;         // Hold CPU in reset
  localparam int CTRL_OWNER_BIT = 1;         // Loader owns the ROM port
  localparam int CTRL_HALT_BIT  = 2;         // Halt the CPU

  // CPU halted until the loader releases it
  localparam logic [CTRL_W-1:0] CTRL_INIT = 8'd4;

  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_CTRL,
    TGT_OTHER                                // Ignored by the loader path
  } ldr_target_e;

endpackage

//--- source/bus_pkg.sv
package bus_pkg;

  // ============================================================
  // CPU bus geometry
  // ============================================================
  localparam int ADDR_HI = 23;               // 68000 word address, A23..A1
  localparam int ADDR_LO = 1;
  localparam int DATA_W  = 16;               // Data bus
  localparam int BYTE_W  = 8;                // One byte lane

  // Region select inside each 256K block
  localparam int REGION_MSB = 17;
  localparam int REGION_LSB = 15;

  // Peripheral window 0x600000, tag on A23..A18
  localparam int         PERIPH_LSB = 18;
  localparam logic [5:0] PERIPH_TAG = 6'b011000;

  // ============================================================
  // Block RAM sizes, in words
  // ============================================================
  localparam int ROM_AW  = 15;               // 64K bytes, two regions
  localparam int VRAM_AW = 14;               // 32K bytes
  localparam int RAM_AW  = 14;               // 32K bytes, mirrored over 3..7

  // ============================================================
  // Timing generators
  // ============================================================
  // 25 MHz / 163 gives 16 x 9600 baud
  localparam int BAUD_LAST      = 162;
  localparam int BAUD_HIGH_FROM = 82;        // High half of the baud period
  localparam int BAUD_W         = $clog2(BAUD_LAST + 1);

  localparam int POR_BITS = 4;               // Power-on hold, 15 cycles

  // Memory region seen by the CPU
  typedef enum logic [2:0] {
    REG_ROM  = 3'd0,                         // Regions 0 and 1
    REG_VRAM = 3'd2,
    REG_RAM  = 3'd3                          // Regions 3 to 7
  } region_e;

endpackage
